/* source/isaPkg.sv */
package isaPkg;

	////////////////////////////////////////
	// word layout
	////////////////////////////////////////

	// full instruction word, prefix included
	localparam int instWidth = 18;

	// prefix values
	localparam logic [1:0] prefixShort = 2'b00;
	// long form carries a whole 16-bit constant
	localparam logic [1:0] prefixLong = 2'b11;

	////////////////////////////////////////
	// major codes
	////////////////////////////////////////

	localparam logic [3:0] majReg = 4'b0000;
	localparam logic [3:0] majMem = 4'b0100;
	localparam logic [3:0] majShift = 4'b1000;
	// immediate majors, minor field holds imm[7:4]
	localparam logic [3:0] majAddi = 4'b0101;
	localparam logic [3:0] majAddui = 4'b0110;
	localparam logic [3:0] majAddci = 4'b0111;
	localparam logic [3:0] majAddcui = 4'b1010;
	localparam logic [3:0] majSubi = 4'b1001;
	localparam logic [3:0] majCmpi = 4'b1011;
	localparam logic [3:0] majCmpui = 4'b1110;
	localparam logic [3:0] majMovi = 4'b1101;
	localparam logic [3:0] majLui = 4'b1111;

	////////////////////////////////////////
	// minor codes
	////////////////////////////////////////

	// register group
	localparam logic [3:0] minAdd = 4'b0101;
	localparam logic [3:0] minAddu = 4'b0110;
	localparam logic [3:0] minAddc = 4'b0111;
	localparam logic [3:0] minAddcu = 4'b0100;
	localparam logic [3:0] minSub = 4'b1001;
	localparam logic [3:0] minCmp = 4'b1011;
	localparam logic [3:0] minAnd = 4'b0001;
	localparam logic [3:0] minOr = 4'b0010;
	localparam logic [3:0] minXor = 4'b0011;
	localparam logic [3:0] minNot = 4'b1111;
	localparam logic [3:0] minMov = 4'b1101;
	// shift group, immediate counts are unsigned
	localparam logic [3:0] minLsh = 4'b0100;
	localparam logic [3:0] minLshi = 4'b0000;
	localparam logic [3:0] minRsh = 4'b1100;
	localparam logic [3:0] minRshi = 4'b0001;
	localparam logic [3:0] minAlsh = 4'b0101;
	localparam logic [3:0] minArsh = 4'b1101;
	// memory group
	localparam logic [3:0] minLoad = 4'b0000;
	localparam logic [3:0] minStor = 4'b0100;
	localparam logic [3:0] minJcond = 4'b1100;

	// branch conditions in the source field of jcond
	localparam logic [3:0] condBeq = 4'b0000;
	localparam logic [3:0] condBneq = 4'b0001;
	localparam logic [3:0] condBgt = 4'b0110;
	localparam logic [3:0] condBlt = 4'b0111;
	localparam logic [3:0] condJuc = 4'b1110;

	////////////////////////////////////////
	// instruction word views
	////////////////////////////////////////

	typedef struct packed {
		logic [1:0] prefix;
		logic [3:0] major;
		logic [3:0] dest;
		logic [3:0] minor;
		logic [3:0] src;
	} regView;

	typedef struct packed {
		logic [1:0] prefix;
		logic [3:0] major;
		logic [3:0] dest;
		logic [7:0] imm;
	} immView;

	// destination sits in value[11:8], same bits as the short form
	typedef struct packed {
		logic [1:0] prefix;
		logic [15:0] value;
	} longView;

	typedef union packed {
		regView r;
		immView i;
		longView l;
	} instWord;

endpackage

/* source/execPkg.sv */
package execPkg;

	// datapath
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;

	////////////////////////////////////////
	// flag word
	////////////////////////////////////////

	localparam int flagWidth = 5;
	localparam int flagCarry = 0;
	localparam int flagOverflow = 1;
	localparam int flagZero = 2;
	// unsigned a < b
	localparam int flagLow = 3;
	// signed a < b
	localparam int flagNeg = 4;

	////////////////////////////////////////
	// micro-op word, msb first
	// op, imm, selImm, store, regA, regB, dest
	////////////////////////////////////////

	localparam int opWidth = 8;
	localparam int uopWidth = opWidth + dataWidth + 2 + 3 * regAddrWidth;

	localparam int uopDestLsb = 0;
	localparam int uopRegBLsb = uopDestLsb + regAddrWidth;
	localparam int uopRegALsb = uopRegBLsb + regAddrWidth;
	localparam int uopStoreBit = uopRegALsb + regAddrWidth;
	localparam int uopSelImmBit = uopStoreBit + 1;
	localparam int uopImmLsb = uopSelImmBit + 1;
	localparam int uopOpLsb = uopImmLsb + dataWidth;

endpackage

/* source/instDecoder.sv */
module instDecoder (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          instValid,
	output logic                          instReady,
	input  logic [isaPkg::instWidth-1:0]  instData,
	output logic                          decValid,
	input  logic                          decReady,
	output logic [execPkg::uopWidth-1:0]  decUop
);

	isaPkg::instWord word;

	// decoded fields
	logic [execPkg::opWidth-1:0] op;
	logic [execPkg::dataWidth-1:0] imm;
	logic selImm;
	logic store;
	logic [execPkg::regAddrWidth-1:0] regA;
	logic [execPkg::regAddrWidth-1:0] regB;
	logic [execPkg::regAddrWidth-1:0] dest;
	logic [execPkg::uopWidth-1:0] uopNext;

	assign word = instData;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	always_comb begin
		// default is the no-op, or of dest with itself
		op = {isaPkg::majReg, isaPkg::minOr};
		imm = '0;
		selImm = 1'b0;
		store = 1'b0;
		regA = word.r.dest;
		regB = word.r.dest;
		dest = word.r.dest;
		if (word.r.prefix == isaPkg::prefixShort) begin
			case (word.r.major)
				isaPkg::majReg: begin
					case (word.r.minor)
						isaPkg::minAdd, isaPkg::minAddu, isaPkg::minAddc, isaPkg::minAddcu,
						isaPkg::minSub, isaPkg::minCmp, isaPkg::minAnd, isaPkg::minOr,
						isaPkg::minXor, isaPkg::minNot: begin
							op = {isaPkg::majReg, word.r.minor};
							regB = word.r.src;
						end
						isaPkg::minMov: begin
							// source read on both ports
							op = {isaPkg::majReg, isaPkg::minMov};
							regA = word.r.src;
							regB = word.r.src;
						end
						default: ;
					endcase
				end
				// signed immediates
				isaPkg::majAddi, isaPkg::majAddci, isaPkg::majSubi, isaPkg::majCmpi: begin
					op = {word.r.major, word.r.minor};
					selImm = 1'b1;
					imm = {{8{word.i.imm[7]}}, word.i.imm};
				end
				// unsigned immediates
				isaPkg::majAddui, isaPkg::majAddcui, isaPkg::majCmpui, isaPkg::majMovi: begin
					op = {word.r.major, word.r.minor};
					selImm = 1'b1;
					imm = {8'h00, word.i.imm};
				end
				isaPkg::majLui: begin
					op = {isaPkg::majLui, word.r.minor};
					selImm = 1'b1;
					imm = {word.i.imm, 8'h00};
				end
				isaPkg::majShift: begin
					case (word.r.minor)
						isaPkg::minLsh, isaPkg::minRsh, isaPkg::minAlsh, isaPkg::minArsh: begin
							op = {isaPkg::majShift, word.r.minor};
							regB = word.r.src;
						end
						isaPkg::minLshi, isaPkg::minRshi: begin
							// 4-bit count from the source field
							op = {isaPkg::majShift, word.r.minor};
							selImm = 1'b1;
							imm = {12'h000, word.r.src};
						end
						default: ;
					endcase
				end
				isaPkg::majMem: begin
					case (word.r.minor)
						isaPkg::minStor: begin
							// address reg in dest, data reg in src
							op = {isaPkg::majReg, isaPkg::minMov};
							regB = word.r.src;
							store = 1'b1;
						end
						// no memory read or pc here
						isaPkg::minLoad, isaPkg::minJcond: ;
						default: ;
					endcase
				end
				default: ;
			endcase
		end else if (word.r.prefix == isaPkg::prefixLong) begin
			// full constant, executes as lui
			op = {isaPkg::majLui, word.r.minor};
			selImm = 1'b1;
			imm = word.l.value;
		end
	end

	assign uopNext = {op, imm, selImm, store, regA, regB, dest};

	////////////////////////////////////////
	// output stage
	////////////////////////////////////////

	// empty or draining this cycle
	assign instReady = !decValid || decReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else if (instReady) begin
			decValid <= instValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instValid && instReady) begin
			decUop <= uopNext;
		end
	end

endmodule

/* source/uopQueue.sv */
module uopQueue #(
	parameter int queueDepth = 4,
	parameter int uopBits = 38
) (
	input  logic               clk,
	input  logic               arstN,
	input  logic               inValid,
	output logic               inReady,
	input  logic [uopBits-1:0] inUop,
	output logic               outValid,
	input  logic               outReady,
	output logic [uopBits-1:0] outUop
);

	localparam int ptrWidth = $clog2(queueDepth);
	localparam int cntWidth = $clog2(queueDepth + 1);

	logic [uopBits-1:0] mem [queueDepth];
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] wrPtr;
	logic [cntWidth-1:0] count;
	logic push;
	logic pop;
	logic full;

	assign full = (count == cntWidth'(queueDepth));
	assign outValid = (count != '0);
	// head read straight from storage
	assign outUop = mem[rdPtr];

	// full queue still takes a word when the head leaves
	assign inReady = !full || outReady;
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				// wrap for depths that are not a power of two
				wrPtr <= (wrPtr == ptrWidth'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrWidth'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inUop;
		end
	end

endmodule

/* source/executeUnit.sv */
module executeUnit (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic                              qValid,
	output logic                              qReady,
	input  logic [execPkg::uopWidth-1:0]      qUop,
	output logic                              wbValid,
	output logic [execPkg::regAddrWidth-1:0]  wbReg,
	output logic [execPkg::dataWidth-1:0]     wbData,
	output logic [execPkg::flagWidth-1:0]     flags,
	output logic                              storeValid,
	input  logic                              storeReady,
	output logic [execPkg::dataWidth-1:0]     storeAddr,
	output logic [execPkg::dataWidth-1:0]     storeData
);

	localparam int msb = execPkg::dataWidth - 1;

	logic [execPkg::dataWidth-1:0] regFile [execPkg::regCount];

	// micro-op fields
	logic [3:0] major;
	logic [3:0] minor;
	logic [execPkg::dataWidth-1:0] imm;
	logic selImm;
	logic isStore;
	logic [execPkg::regAddrWidth-1:0] regA;
	logic [execPkg::regAddrWidth-1:0] regB;
	logic [execPkg::regAddrWidth-1:0] dest;

	// operands and alu
	logic [execPkg::dataWidth-1:0] opA;
	logic [execPkg::dataWidth-1:0] opB;
	logic useCarryIn;
	logic [execPkg::dataWidth:0] addSum;
	logic [execPkg::dataWidth:0] subDiff;
	logic [execPkg::dataWidth-1:0] aluResult;
	logic [execPkg::flagWidth-1:0] flagsNext;
	logic isCompare;
	logic pop;

	assign {major, minor} = qUop[execPkg::uopOpLsb +: execPkg::opWidth];
	assign imm = qUop[execPkg::uopImmLsb +: execPkg::dataWidth];
	assign selImm = qUop[execPkg::uopSelImmBit];
	assign isStore = qUop[execPkg::uopStoreBit];
	assign regA = qUop[execPkg::uopRegALsb +: execPkg::regAddrWidth];
	assign regB = qUop[execPkg::uopRegBLsb +: execPkg::regAddrWidth];
	assign dest = qUop[execPkg::uopDestLsb +: execPkg::regAddrWidth];

	// pending store blocks the queue
	assign qReady = !storeValid || storeReady;
	assign pop = qValid && qReady;

	assign opA = regFile[regA];
	assign opB = selImm ? imm : regFile[regB];

	assign useCarryIn = (major == isaPkg::majAddci) || (major == isaPkg::majAddcui) ||
		((major == isaPkg::majReg) &&
		((minor == isaPkg::minAddc) || (minor == isaPkg::minAddcu)));
	assign addSum = {1'b0, opA} + {1'b0, opB} +
		{{execPkg::dataWidth{1'b0}}, useCarryIn & flags[execPkg::flagCarry]};
	// top bit is the borrow
	assign subDiff = {1'b0, opA} - {1'b0, opB};

	////////////////////////////////////////
	// alu and flags
	////////////////////////////////////////

	always_comb begin
		aluResult = opA | opB;
		flagsNext = flags;
		isCompare = 1'b0;
		case (major)
			isaPkg::majReg: begin
				case (minor)
					isaPkg::minAdd, isaPkg::minAddu, isaPkg::minAddc, isaPkg::minAddcu: begin
						aluResult = addSum[msb:0];
						flagsNext[execPkg::flagCarry] = addSum[msb+1];
						flagsNext[execPkg::flagOverflow] = (opA[msb] == opB[msb]) &&
							(addSum[msb] != opA[msb]);
					end
					isaPkg::minSub: begin
						aluResult = subDiff[msb:0];
						flagsNext[execPkg::flagCarry] = subDiff[msb+1];
						flagsNext[execPkg::flagOverflow] = (opA[msb] != opB[msb]) &&
							(subDiff[msb] != opA[msb]);
					end
					isaPkg::minCmp: isCompare = 1'b1;
					isaPkg::minAnd: aluResult = opA & opB;
					isaPkg::minXor: aluResult = opA ^ opB;
					isaPkg::minNot: aluResult = ~opB;
					isaPkg::minMov: aluResult = opB;
					default: ;
				endcase
			end
			isaPkg::majAddi, isaPkg::majAddui, isaPkg::majAddci, isaPkg::majAddcui: begin
				aluResult = addSum[msb:0];
				flagsNext[execPkg::flagCarry] = addSum[msb+1];
				flagsNext[execPkg::flagOverflow] = (opA[msb] == opB[msb]) &&
					(addSum[msb] != opA[msb]);
			end
			isaPkg::majSubi: begin
				aluResult = subDiff[msb:0];
				flagsNext[execPkg::flagCarry] = subDiff[msb+1];
				flagsNext[execPkg::flagOverflow] = (opA[msb] != opB[msb]) &&
					(subDiff[msb] != opA[msb]);
			end
			isaPkg::majCmpi, isaPkg::majCmpui: isCompare = 1'b1;
			// constant already shaped by the decoder
			isaPkg::majMovi, isaPkg::majLui: aluResult = opB;
			isaPkg::majShift: begin
				case (minor)
					isaPkg::minLsh, isaPkg::minLshi, isaPkg::minAlsh: aluResult = opA << opB[3:0];
					isaPkg::minRsh, isaPkg::minRshi: aluResult = opA >> opB[3:0];
					isaPkg::minArsh: aluResult = $signed(opA) >>> opB[3:0];
					default: ;
				endcase
			end
			default: ;
		endcase
		if (isCompare) begin
			flagsNext[execPkg::flagZero] = (opA == opB);
			flagsNext[execPkg::flagLow] = (opA < opB);
			flagsNext[execPkg::flagNeg] = ($signed(opA) < $signed(opB));
		end
	end

	////////////////////////////////////////
	// state update
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < execPkg::regCount; i++) begin
				regFile[i] <= '0;
			end
			flags <= '0;
			wbValid <= 1'b0;
			storeValid <= 1'b0;
		end else begin
			// one-cycle pulse per register write
			wbValid <= pop && !isCompare && !isStore;
			if (pop) begin
				flags <= flagsNext;
				storeValid <= isStore;
				if (!isCompare && !isStore) begin
					regFile[dest] <= aluResult;
				end
			end else if (storeReady) begin
				storeValid <= 1'b0;
			end
		end
	end

	// result and store payload
	always_ff @(posedge clk) begin
		if (pop) begin
			wbReg <= dest;
			wbData <= aluResult;
			if (isStore) begin
				storeAddr <= opA;
				storeData <= opB;
			end
		end
	end

endmodule

/* source/decodeExecTop.sv */
module decodeExecTop #(
	parameter int queueDepth = 4
) (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic                              instValid,
	output logic                              instReady,
	input  logic [isaPkg::instWidth-1:0]      instData,
	output logic                              wbValid,
	output logic [execPkg::regAddrWidth-1:0]  wbReg,
	output logic [execPkg::dataWidth-1:0]     wbData,
	output logic [execPkg::flagWidth-1:0]     flags,
	output logic                              storeValid,
	input  logic                              storeReady,
	output logic [execPkg::dataWidth-1:0]     storeAddr,
	output logic [execPkg::dataWidth-1:0]     storeData
);

	// decoder to queue
	logic decValid;
	logic decReady;
	logic [execPkg::uopWidth-1:0] decUop;

	// queue to execute
	logic qValid;
	logic qReady;
	logic [execPkg::uopWidth-1:0] qUop;

	instDecoder i_instDecoder (
		.clk       (clk),
		.arstN     (arstN),
		.instValid (instValid),
		.instReady (instReady),
		.instData  (instData),
		.decValid  (decValid),
		.decReady  (decReady),
		.decUop    (decUop)
	);

	// word written at an edge is the head right after it
	uopQueue #(
		.queueDepth (queueDepth),
		.uopBits    (execPkg::uopWidth)
	) i_uopQueue (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (decValid),
		.inReady  (decReady),
		.inUop    (decUop),
		.outValid (qValid),
		.outReady (qReady),
		.outUop   (qUop)
	);

	executeUnit i_executeUnit (
		.clk        (clk),
		.arstN      (arstN),
		.qValid     (qValid),
		.qReady     (qReady),
		.qUop       (qUop),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.flags      (flags),
		.storeValid (storeValid),
		.storeReady (storeReady),
		.storeAddr  (storeAddr),
		.storeData  (storeData)
	);

endmodule

/* bench/decodeExecTb.sv */
module decodeExecTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 10;
	localparam int stallCycles = 20;
	// instructions over all tests, stores at their upper bound
	localparam int totalInst = 64;
	localparam int cycleLimit = 10 * totalInst + resetCycles + stallCycles;

	logic clk;
	logic arstN;
	logic instValid;
	logic instReady;
	logic [isaPkg::instWidth-1:0] instData;
	logic wbValid;
	logic [execPkg::regAddrWidth-1:0] wbReg;
	logic [execPkg::dataWidth-1:0] wbData;
	logic [execPkg::flagWidth-1:0] flags;
	logic storeValid;
	logic storeReady;
	logic [execPkg::dataWidth-1:0] storeAddr;
	logic [execPkg::dataWidth-1:0] storeData;

	// reference model
	logic [execPkg::dataWidth-1:0] regs [execPkg::regCount];
	logic [execPkg::flagWidth-1:0] flagsM;

	// observed results, in order
	logic [execPkg::regAddrWidth-1:0] wbRegQ [$];
	logic [execPkg::dataWidth-1:0] wbDataQ [$];
	logic [execPkg::flagWidth-1:0] wbFlagsQ [$];
	logic [execPkg::dataWidth-1:0] stAddrQ [$];
	logic [execPkg::dataWidth-1:0] stDataQ [$];

	logic [31:0] seed = 32'h43be_493e;
	int cycles = 0;

	decodeExecTop #(
		.queueDepth (4)
	) i_decodeExecTop (
		.clk        (clk),
		.arstN      (arstN),
		.instValid  (instValid),
		.instReady  (instReady),
		.instData   (instData),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.flags      (flags),
		.storeValid (storeValid),
		.storeReady (storeReady),
		.storeAddr  (storeAddr),
		.storeData  (storeData)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			failRun("timeout, the run did not finish in time");
		end
	end

	// sample outputs well after the falling edge
	always begin
		@(negedge clk);
		#2;
		if (wbValid) begin
			wbRegQ.push_back(wbReg);
			wbDataQ.push_back(wbData);
			wbFlagsQ.push_back(flags);
		end
		if (storeValid && storeReady) begin
			stAddrQ.push_back(storeAddr);
			stDataQ.push_back(storeData);
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [17:0] regInst(logic [3:0] major, logic [3:0] d, logic [3:0] minor,
		logic [3:0] s);
		return {isaPkg::prefixShort, major, d, minor, s};
	endfunction

	function automatic logic [17:0] immInst(logic [3:0] major, logic [3:0] d, logic [7:0] imm);
		return {isaPkg::prefixShort, major, d, imm};
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkWb(input logic [execPkg::regAddrWidth-1:0] expReg,
		input logic [execPkg::dataWidth-1:0] expData,
		input logic [execPkg::regAddrWidth-1:0] gotReg,
		input logic [execPkg::dataWidth-1:0] gotData);
		if (gotReg !== expReg) begin
			failRun($sformatf("mismatch at %0t: wbReg exp %h got %h", $time, expReg, gotReg));
		end
		if (gotData !== expData) begin
			failRun($sformatf("mismatch at %0t: wbData exp %h got %h", $time, expData, gotData));
		end
	endtask

	task automatic checkFlags(input logic [execPkg::flagWidth-1:0] expFlags,
		input logic [execPkg::flagWidth-1:0] gotFlags);
		if (gotFlags !== expFlags) begin
			failRun($sformatf("mismatch at %0t: flags exp %b got %b", $time, expFlags, gotFlags));
		end
	endtask

	task automatic checkStore(input logic [execPkg::dataWidth-1:0] expAddr,
		input logic [execPkg::dataWidth-1:0] expData,
		input logic [execPkg::dataWidth-1:0] gotAddr,
		input logic [execPkg::dataWidth-1:0] gotData);
		if (gotAddr !== expAddr) begin
			failRun($sformatf("mismatch at %0t: storeAddr exp %h got %h", $time, expAddr, gotAddr));
		end
		if (gotData !== expData) begin
			failRun($sformatf("mismatch at %0t: storeData exp %h got %h", $time, expData, gotData));
		end
	endtask

	// called on a falling edge, returns on the one after the transfer
	task automatic sendInst(input logic [isaPkg::instWidth-1:0] w);
		instValid = 1'b1;
		instData = w;
		#1;
		while (!instReady) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		instValid = 1'b0;
	endtask

	task automatic expectWb(input logic [3:0] d, input logic [15:0] data);
		while (wbRegQ.size() == 0) begin
			@(negedge clk);
		end
		checkWb(d, data, wbRegQ.pop_front(), wbDataQ.pop_front());
		checkFlags(flagsM, wbFlagsQ.pop_front());
	endtask

	task automatic runOp(input logic [17:0] w, input logic [3:0] d, input logic [15:0] result);
		sendInst(w);
		regs[d] = result;
		expectWb(d, result);
	endtask

	task automatic doAdd(input logic [17:0] w, input logic [3:0] d, input logic [15:0] a,
		input logic [15:0] b, input logic cin);
		logic [16:0] sum;
		sum = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
		flagsM[execPkg::flagCarry] = sum[16];
		// same input signs, different result sign
		flagsM[execPkg::flagOverflow] = (a[15] == b[15]) && (sum[15] != a[15]);
		runOp(w, d, sum[15:0]);
	endtask

	task automatic doSub(input logic [17:0] w, input logic [3:0] d, input logic [15:0] a,
		input logic [15:0] b);
		logic [16:0] diff;
		diff = {1'b0, a} - {1'b0, b};
		flagsM[execPkg::flagCarry] = diff[16];
		flagsM[execPkg::flagOverflow] = (a[15] != b[15]) && (diff[15] != a[15]);
		runOp(w, d, diff[15:0]);
	endtask

	// the no-op that follows proves no write-back came from the compare
	task automatic doCmp(input logic [17:0] w, input logic [15:0] a, input logic [15:0] b);
		flagsM[execPkg::flagZero] = (a == b);
		flagsM[execPkg::flagLow] = (a < b);
		flagsM[execPkg::flagNeg] = ($signed(a) < $signed(b));
		sendInst(w);
		runOp(regInst(isaPkg::majReg, 4'd0, isaPkg::minOr, 4'd0), 4'd0, regs[0]);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic testLongConst();
		logic [15:0] v;
		if (wbValid !== 1'b0 || storeValid !== 1'b0 || instReady !== 1'b1) begin
			failRun("outputs not in their reset state after reset");
		end
		for (int r = 0; r < execPkg::regCount; r++) begin
			// long form names its register in bits 11:8
			v = nextRand();
			v[11:8] = r[3:0];
			runOp({isaPkg::prefixLong, v}, r[3:0], v);
		end
		runOp(regInst(isaPkg::majReg, 4'd2, isaPkg::minMov, 4'd5), 4'd2, regs[5]);
	endtask

	task automatic testRegAlu();
		doAdd(regInst(isaPkg::majReg, 4'd1, isaPkg::minAdd, 4'd9), 4'd1, regs[1], regs[9], 1'b0);
		doAdd(regInst(isaPkg::majReg, 4'd3, isaPkg::minAddc, 4'd7), 4'd3, regs[3], regs[7],
			flagsM[execPkg::flagCarry]);
		doAdd(regInst(isaPkg::majReg, 4'd4, isaPkg::minAddc, 4'd12), 4'd4, regs[4], regs[12],
			flagsM[execPkg::flagCarry]);
		doSub(regInst(isaPkg::majReg, 4'd6, isaPkg::minSub, 4'd10), 4'd6, regs[6], regs[10]);
		doSub(regInst(isaPkg::majReg, 4'd8, isaPkg::minSub, 4'd11), 4'd8, regs[8], regs[11]);
		runOp(regInst(isaPkg::majReg, 4'd9, isaPkg::minAnd, 4'd13), 4'd9, regs[9] & regs[13]);
		runOp(regInst(isaPkg::majReg, 4'd10, isaPkg::minOr, 4'd14), 4'd10, regs[10] | regs[14]);
		runOp(regInst(isaPkg::majReg, 4'd11, isaPkg::minXor, 4'd15), 4'd11, regs[11] ^ regs[15]);
		runOp(regInst(isaPkg::majReg, 4'd12, isaPkg::minNot, 4'd1), 4'd12, ~regs[1]);
	endtask

	task automatic testImmediates();
		logic [7:0] imm;
		imm = nextRand() | 8'h80;
		doAdd(immInst(isaPkg::majAddi, 4'd1, imm), 4'd1, regs[1], {8'hff, imm}, 1'b0);
		imm = nextRand() | 8'h80;
		doSub(immInst(isaPkg::majSubi, 4'd2, imm), 4'd2, regs[2], {8'hff, imm});
		imm = nextRand() | 8'h80;
		doAdd(immInst(isaPkg::majAddui, 4'd3, imm), 4'd3, regs[3], {8'h00, imm}, 1'b0);
		imm = nextRand() | 8'h80;
		doCmp(immInst(isaPkg::majCmpui, 4'd4, imm), regs[4], {8'h00, imm});
		imm = nextRand();
		runOp(immInst(isaPkg::majLui, 4'd5, imm), 4'd5, {imm, 8'h00});
		runOp(regInst(isaPkg::majShift, 4'd6, isaPkg::minLshi, 4'd5), 4'd6, regs[6] << 5);
		runOp(regInst(isaPkg::majShift, 4'd7, isaPkg::minRshi, 4'd11), 4'd7, regs[7] >> 11);
	endtask

	task automatic testCompare();
		runOp({isaPkg::prefixLong, 16'h1305}, 4'd3, 16'h1305);
		runOp(regInst(isaPkg::majReg, 4'd4, isaPkg::minMov, 4'd3), 4'd4, regs[3]);
		runOp({isaPkg::prefixLong, 16'h0500}, 4'd5, 16'h0500);
		runOp({isaPkg::prefixLong, 16'h8600}, 4'd6, 16'h8600);
		// equal, unsigned lower, signed lower, and a negative immediate
		doCmp(regInst(isaPkg::majReg, 4'd3, isaPkg::minCmp, 4'd4), regs[3], regs[4]);
		doCmp(regInst(isaPkg::majReg, 4'd5, isaPkg::minCmp, 4'd6), regs[5], regs[6]);
		doCmp(regInst(isaPkg::majReg, 4'd6, isaPkg::minCmp, 4'd5), regs[6], regs[5]);
		doCmp(immInst(isaPkg::majCmpi, 4'd5, 8'hff), regs[5], 16'hffff);
	endtask

	task automatic testStoreStall();
		int sent;
		logic [3:0] a;
		logic [3:0] s;
		sent = 0;
		storeReady = 1'b0;
		// fill until the pipe pushes back
		forever begin
			a = sent[3:0];
			s = a + 4'd5;
			instValid = 1'b1;
			instData = regInst(isaPkg::majMem, a, isaPkg::minStor, s);
			#1;
			if (!instReady) break;
			@(posedge clk);
			@(negedge clk);
			sent++;
			if (sent > 11) failRun("instReady never dropped while stores were blocked");
		end
		if (sent < 5) failRun("instReady dropped before the queue could fill");
		repeat (stallCycles) begin
			@(negedge clk);
			#1;
			if (instReady) failRun("instReady rose while stores were still blocked");
			if (storeValid !== 1'b1) failRun("storeValid dropped while storeReady was low");
			// first store waits with its payload held
			checkStore(regs[0], regs[5], storeAddr, storeData);
		end
		@(negedge clk);
		storeReady = 1'b1;
		sendInst(regInst(isaPkg::majMem, a, isaPkg::minStor, s));
		for (int i = 0; i <= sent; i++) begin
			a = i[3:0];
			s = a + 4'd5;
			while (stAddrQ.size() == 0) @(negedge clk);
			checkStore(regs[a], regs[s], stAddrQ.pop_front(), stDataQ.pop_front());
		end
		if (wbRegQ.size() != 0) failRun("a store produced a register write-back");
		runOp(regInst(isaPkg::majReg, 4'd2, isaPkg::minXor, 4'd9), 4'd2, regs[2] ^ regs[9]);
		doAdd(regInst(isaPkg::majReg, 4'd8, isaPkg::minAdd, 4'd2), 4'd8, regs[8], regs[2], 1'b0);
	endtask

	task automatic testNoOps();
		runOp(regInst(isaPkg::majMem, 4'd9, isaPkg::minLoad, 4'd3), 4'd9, regs[9]);
		runOp(regInst(isaPkg::majMem, 4'd10, isaPkg::minJcond, isaPkg::condJuc), 4'd10, regs[10]);
		// major 0011 is unassigned
		runOp(regInst(4'b0011, 4'd11, 4'b1010, 4'd2), 4'd11, regs[11]);
	endtask

	initial begin
		arstN = 1'b0;
		instValid = 1'b0;
		instData = '0;
		storeReady = 1'b1;
		flagsM = '0;
		for (int i = 0; i < execPkg::regCount; i++) begin
			regs[i] = '0;
		end
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		testLongConst();
		testRegAlu();
		testImmediates();
		testCompare();
		testStoreStall();
		testNoOps();
		repeat (5) @(negedge clk);
		if (wbRegQ.size() != 0 || stAddrQ.size() != 0) begin
			failRun("unexpected results left over at the end of the run");
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* decodeExec.f */
source/isaPkg.sv
source/execPkg.sv
source/instDecoder.sv
source/uopQueue.sv
source/executeUnit.sv
source/decodeExecTop.sv
bench/decodeExecTb.sv

/* Bender.yml */
package:
  name: decodeExec

sources:
  - source/isaPkg.sv
  - source/execPkg.sv
  - source/instDecoder.sv
  - source/uopQueue.sv
  - source/executeUnit.sv
  - source/decodeExecTop.sv
  - target: test
    files:
      - bench/decodeExecTb.sv
